/* Bender.yml */
package:
  name: mips_pipe

export_include_dirs:
  - .

sources:
  - mips_pipe_pkg.sv
  - control_unit.sv
  - register_file.sv
  - alu.sv
  - forward_unit.sv
  - hazard_unit.sv
  - datapath.sv
  - target: simulation
    files:
      - tb_datapath.sv

/* alu.sv */
module alu import mips_pipe_pkg::*; (
  input  word_t  port_a,
  input  word_t  port_b,
  input  aluop_t alu_op,
  output word_t  result,
  output logic   zero
);

  always_comb begin
    case (alu_op)
      ALU_ADD: result = port_a + port_b;
      ALU_SUB: result = port_a - port_b;
      ALU_AND: result = port_a & port_b;
      ALU_OR:  result = port_a | port_b;
      // signed compare
      ALU_SLT: begin
        if ($signed(port_a) < $signed(port_b)) begin
          result = 32'd1;
        end else begin
          result = 32'd0;
        end
      end
      // immediate already shifted by the extender
      ALU_LUI: result = port_b;
      default: result = '0;
    endcase
  end

  // used by BEQ and BNE
  assign zero = (result == '0);

endmodule

/* control_unit.sv */
module control_unit import mips_pipe_pkg::*; (
  input  instr_t  instr,
  output aluop_t  alu_op,
  output alusrc_t alu_src,
  output regdst_t reg_dst,
  output wbsel_t  wb_sel,
  output extsel_t ext_sel,
  output logic    reg_wen,
  output logic    mem_ren,
  output logic    mem_wen,
  output logic    is_branch,
  output logic    branch_ne,
  output logic    is_jump,
  output logic    is_jr,
  output logic    is_halt
);

  always_comb begin
    // no-op unless the opcode says otherwise
    alu_op    = ALU_ADD;
    alu_src   = SRC_REG;
    reg_dst   = DST_RD;
    wb_sel    = WB_ALU;
    ext_sel   = EXT_ZERO;
    reg_wen   = 1'b0;
    mem_ren   = 1'b0;
    mem_wen   = 1'b0;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    is_jump   = 1'b0;
    is_jr     = 1'b0;
    is_halt   = 1'b0;

    case (instr.r.opcode)
      RTYPE: begin
        reg_wen = 1'b1;
        case (instr.r.funct)
          ADDU:    alu_op = ALU_ADD;
          SUBU:    alu_op = ALU_SUB;
          AND:     alu_op = ALU_AND;
          OR:      alu_op = ALU_OR;
          SLT:     alu_op = ALU_SLT;
          JR: begin
            reg_wen = 1'b0;
            is_jr   = 1'b1;
          end
          default: reg_wen = 1'b0;
        endcase
      end
      J:       is_jump = 1'b1;
      JAL: begin
        is_jump = 1'b1;
        reg_wen = 1'b1;
        reg_dst = DST_LINK;
        wb_sel  = WB_NPC;
      end
      // compare by subtraction, offset sign extended
      BEQ, BNE: begin
        is_branch = 1'b1;
        branch_ne = (instr.r.opcode == BNE);
        alu_op    = ALU_SUB;
        ext_sel   = EXT_SIGN;
      end
      ADDIU, ORI, LUI, LW: begin
        alu_src = SRC_IMM;
        reg_dst = DST_RT;
        reg_wen = 1'b1;
        case (instr.r.opcode)
          ORI:     alu_op = ALU_OR;
          LUI: begin
            alu_op  = ALU_LUI;
            ext_sel = EXT_UPPER;
          end
          default: ext_sel = EXT_SIGN;
        endcase
        if (instr.r.opcode == LW) begin
          wb_sel  = WB_LOAD;
          mem_ren = 1'b1;
        end
      end
      SW: begin
        alu_src = SRC_IMM;
        ext_sel = EXT_SIGN;
        mem_wen = 1'b1;
      end
      HALT:    is_halt = 1'b1;
      default: reg_wen = 1'b0;
    endcase
  end

endmodule

/* datapath.sv */
`include "mips_pipe_settings.svh"

module datapath import mips_pipe_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  ihit,
  input  word_t imemload,
  input  logic  dhit,
  input  word_t dmemload,
  output logic  imemREN,
  output word_t imemaddr,
  output logic  dmemREN,
  output logic  dmemWEN,
  output word_t dmemaddr,
  output word_t dmemstore,
  output logic  halt
);

  logic     pc_en, en_ifid, en_idex, en_exmem, en_memwb;
  logic     flush_ifid, flush_idex, flush_exmem;
  pcsrc_t   pcsrc;
  fwdsel_t  fwd_a, fwd_b;
  word_t    pc, pc_plus4, next_pc, jump_target, branch_target;
  instr_t   ifid_instr;
  word_t    ifid_npc;
  aluop_t   cu_alu_op;
  alusrc_t  cu_alu_src;
  regdst_t  cu_reg_dst;
  wbsel_t   cu_wb_sel;
  extsel_t  cu_ext_sel;
  logic     cu_reg_wen, cu_mem_ren, cu_mem_wen, cu_branch, cu_branch_ne;
  logic     cu_jump, cu_jr, cu_halt;
  word_t    rdat1, rdat2, imm_ext;
  regbits_t dst_id;
  logic     idex_reg_wen, idex_mem_ren, idex_mem_wen, idex_branch, idex_jr, idex_halt;
  logic     idex_branch_ne;
  aluop_t   idex_alu_op;
  alusrc_t  idex_alu_src;
  wbsel_t   idex_wb_sel;
  word_t    idex_rdat1, idex_rdat2, idex_imm, idex_npc;
  regbits_t idex_rs, idex_rt, idex_dst;
  word_t    opnd_a, opnd_b, alu_b, alu_out;
  logic     alu_zero, branch_taken;
  logic     exmem_reg_wen, exmem_mem_ren, exmem_mem_wen, exmem_halt;
  wbsel_t   exmem_wb_sel;
  word_t    exmem_result, exmem_store, exmem_npc, mem_val;
  regbits_t exmem_dst;
  logic     memwb_reg_wen, memwb_halt;
  wbsel_t   memwb_wb_sel;
  word_t    memwb_result, memwb_npc, load_q, wdat;
  regbits_t memwb_dst;

  // fetch
  assign imemREN  = !halt;
  assign imemaddr = pc;
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (pcsrc)
      PC_JUMP:   next_pc = jump_target;
      PC_BRANCH: next_pc = branch_target;
      PC_JR:     next_pc = opnd_a;
      default:   next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= `DP_PC_INIT;
    end else if (pc_en) begin
      pc <= next_pc;
    end
  end

  // IF/ID, an all-zero word decodes as a no-op
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ifid_instr <= '0;
    end else if (en_ifid) begin
      ifid_instr <= flush_ifid ? '0 : imemload;
    end
  end

  always_ff @(posedge CLK) begin
    if (en_ifid) begin
      ifid_npc <= pc_plus4;
    end
  end

  // decode
  control_unit u_control (
    .instr(ifid_instr), .alu_op(cu_alu_op), .alu_src(cu_alu_src), .reg_dst(cu_reg_dst),
    .wb_sel(cu_wb_sel), .ext_sel(cu_ext_sel), .reg_wen(cu_reg_wen), .mem_ren(cu_mem_ren),
    .mem_wen(cu_mem_wen), .is_branch(cu_branch), .branch_ne(cu_branch_ne),
    .is_jump(cu_jump), .is_jr(cu_jr), .is_halt(cu_halt)
  );

  register_file u_regs (
    .CLK(CLK), .nRST(nRST), .wen(memwb_reg_wen), .wsel(memwb_dst), .wdat(wdat),
    .rsel1(ifid_instr.r.rs), .rsel2(ifid_instr.r.rt), .rdat1(rdat1), .rdat2(rdat2)
  );

  always_comb begin
    case (cu_ext_sel)
      EXT_SIGN:  imm_ext = {{16{ifid_instr.i.imm[15]}}, ifid_instr.i.imm};
      EXT_UPPER: imm_ext = {ifid_instr.i.imm, 16'h0000};
      default:   imm_ext = {16'h0000, ifid_instr.i.imm};
    endcase
  end

  always_comb begin
    case (cu_reg_dst)
      DST_RT:   dst_id = ifid_instr.i.rt;
      DST_LINK: dst_id = `DP_LINK_REG;
      default:  dst_id = ifid_instr.r.rd;
    endcase
  end

  // low 26 bits of the word are the target index
  assign jump_target = {ifid_npc[31:28], ifid_instr.i.rs, ifid_instr.i.rt,
                        ifid_instr.i.imm, 2'b00};

  // ID/EX, only the side-effect flags are cleared for a bubble
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      idex_reg_wen <= 1'b0;
      idex_mem_ren <= 1'b0;
      idex_mem_wen <= 1'b0;
      idex_branch  <= 1'b0;
      idex_jr      <= 1'b0;
      idex_halt    <= 1'b0;
    end else if (en_idex) begin
      idex_reg_wen <= cu_reg_wen && !flush_idex;
      idex_mem_ren <= cu_mem_ren && !flush_idex;
      idex_mem_wen <= cu_mem_wen && !flush_idex;
      idex_branch  <= cu_branch && !flush_idex;
      idex_jr      <= cu_jr && !flush_idex;
      idex_halt    <= cu_halt && !flush_idex;
    end
  end

  always_ff @(posedge CLK) begin
    if (en_idex) begin
      idex_branch_ne <= cu_branch_ne;
      idex_alu_op    <= cu_alu_op;
      idex_alu_src   <= cu_alu_src;
      idex_wb_sel    <= cu_wb_sel;
      idex_rdat1     <= rdat1;
      idex_rdat2     <= rdat2;
      idex_imm       <= imm_ext;
      idex_npc       <= ifid_npc;
      idex_rs        <= ifid_instr.r.rs;
      idex_rt        <= ifid_instr.r.rt;
      idex_dst       <= dst_id;
    end
  end

  // execute
  always_comb begin
    case (fwd_a)
      FWD_MEM: opnd_a = mem_val;
      FWD_WB:  opnd_a = wdat;
      default: opnd_a = idex_rdat1;
    endcase
    case (fwd_b)
      FWD_MEM: opnd_b = mem_val;
      FWD_WB:  opnd_b = wdat;
      default: opnd_b = idex_rdat2;
    endcase
  end

  assign alu_b = (idex_alu_src == SRC_IMM) ? idex_imm : opnd_b;

  alu u_alu (.port_a(opnd_a), .port_b(alu_b), .alu_op(idex_alu_op), .result(alu_out),
             .zero(alu_zero));

  assign branch_target = idex_npc + {idex_imm[29:0], 2'b00};
  assign branch_taken  = idex_branch && (alu_zero != idex_branch_ne);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      exmem_reg_wen <= 1'b0;
      exmem_mem_ren <= 1'b0;
      exmem_mem_wen <= 1'b0;
      exmem_halt    <= 1'b0;
    end else if (en_exmem) begin
      exmem_reg_wen <= idex_reg_wen && !flush_exmem;
      exmem_mem_ren <= idex_mem_ren && !flush_exmem;
      exmem_mem_wen <= idex_mem_wen && !flush_exmem;
      exmem_halt    <= idex_halt && !flush_exmem;
    end
  end

  always_ff @(posedge CLK) begin
    if (en_exmem) begin
      exmem_wb_sel <= idex_wb_sel;
      exmem_result <= alu_out;
      exmem_store  <= opnd_b;
      exmem_npc    <= idex_npc;
      exmem_dst    <= idex_dst;
    end
  end

  // memory, JAL's link value forwards from here too
  assign dmemREN   = exmem_mem_ren;
  assign dmemWEN   = exmem_mem_wen;
  assign dmemaddr  = exmem_result;
  assign dmemstore = exmem_store;
  assign mem_val   = (exmem_wb_sel == WB_NPC) ? exmem_npc : exmem_result;

  always_ff @(posedge CLK) begin
    if (dhit) begin
      load_q <= dmemload;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      memwb_reg_wen <= 1'b0;
      memwb_halt    <= 1'b0;
    end else if (en_memwb) begin
      memwb_reg_wen <= exmem_reg_wen;
      memwb_halt    <= exmem_halt;
    end
  end

  always_ff @(posedge CLK) begin
    if (en_memwb) begin
      memwb_wb_sel <= exmem_wb_sel;
      memwb_result <= exmem_result;
      memwb_npc    <= exmem_npc;
      memwb_dst    <= exmem_dst;
    end
  end

  // write-back
  always_comb begin
    case (memwb_wb_sel)
      WB_LOAD: wdat = load_q;
      WB_NPC:  wdat = memwb_npc;
      default: wdat = memwb_result;
    endcase
  end

  // sticky until reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (memwb_halt) begin
      halt <= 1'b1;
    end
  end

  forward_unit u_forward (
    .rs_ex(idex_rs), .rt_ex(idex_rt), .dst_mem(exmem_dst), .dst_wb(memwb_dst),
    .wen_mem(exmem_reg_wen), .wen_wb(memwb_reg_wen), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  hazard_unit u_hazard (
    .ihit(ihit), .dhit(dhit), .mem_busy(exmem_mem_ren || exmem_mem_wen),
    .load_ex(idex_mem_ren), .rt_ex(idex_rt), .rs_id(ifid_instr.r.rs),
    .rt_id(ifid_instr.r.rt), .jump_id(cu_jump), .branch_taken_ex(branch_taken),
    .jr_ex(idex_jr), .halted(halt || memwb_halt || exmem_halt), .pc_en(pc_en),
    .en_ifid(en_ifid), .en_idex(en_idex), .en_exmem(en_exmem), .en_memwb(en_memwb),
    .flush_ifid(flush_ifid), .flush_idex(flush_idex), .flush_exmem(flush_exmem),
    .pcsrc(pcsrc)
  );

  a_one_data_request: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmemREN && dmemWEN))
    else $error("load and store requested together");

  a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
    else $error("halt dropped without reset");

endmodule

/* forward_unit.sv */
module forward_unit import mips_pipe_pkg::*; (
  input  regbits_t rs_ex,
  input  regbits_t rt_ex,
  input  regbits_t dst_mem,
  input  regbits_t dst_wb,
  input  logic     wen_mem,
  input  logic     wen_wb,
  output fwdsel_t  fwd_a,
  output fwdsel_t  fwd_b
);

  logic mem_live, wb_live;

  // writes to register zero carry nothing
  assign mem_live = wen_mem && (dst_mem != '0);
  assign wb_live  = wen_wb && (dst_wb != '0);

  // the younger result in EX/MEM wins
  always_comb begin
    fwd_a = FWD_NONE;
    if (mem_live && (dst_mem == rs_ex)) begin
      fwd_a = FWD_MEM;
    end else if (wb_live && (dst_wb == rs_ex)) begin
      fwd_a = FWD_WB;
    end
  end

  // also selects the SW store data
  always_comb begin
    fwd_b = FWD_NONE;
    if (mem_live && (dst_mem == rt_ex)) begin
      fwd_b = FWD_MEM;
    end else if (wb_live && (dst_wb == rt_ex)) begin
      fwd_b = FWD_WB;
    end
  end

endmodule

/* hazard_unit.sv */
module hazard_unit import mips_pipe_pkg::*; (
  input  logic     ihit,
  input  logic     dhit,
  input  logic     mem_busy,
  input  logic     load_ex,
  input  regbits_t rt_ex,
  input  regbits_t rs_id,
  input  regbits_t rt_id,
  input  logic     jump_id,
  input  logic     branch_taken_ex,
  input  logic     jr_ex,
  input  logic     halted,
  output logic     pc_en,
  output logic     en_ifid,
  output logic     en_idex,
  output logic     en_exmem,
  output logic     en_memwb,
  output logic     flush_ifid,
  output logic     flush_idex,
  output logic     flush_exmem,
  output pcsrc_t   pcsrc
);

  logic load_use;

  // loaded value not ready for the instruction in ID
  assign load_use = load_ex && (rt_ex != '0) && ((rt_ex == rs_id) || (rt_ex == rt_id));

  always_comb begin
    pc_en       = 1'b1;
    en_ifid     = 1'b1;
    en_idex     = 1'b1;
    en_exmem    = 1'b1;
    en_memwb    = 1'b1;
    flush_ifid  = 1'b0;
    flush_idex  = 1'b0;
    flush_exmem = 1'b0;
    pcsrc       = PC_SEQ;

    if (mem_busy && !dhit) begin
      // data access pending, hold everything
      pc_en    = 1'b0;
      en_ifid  = 1'b0;
      en_idex  = 1'b0;
      en_exmem = 1'b0;
      en_memwb = 1'b0;
    end else if (halted) begin
      // drain HALT, drop everything younger
      pc_en       = 1'b0;
      flush_ifid  = 1'b1;
      flush_idex  = 1'b1;
      flush_exmem = 1'b1;
    end else if (branch_taken_ex || jr_ex) begin
      pcsrc      = jr_ex ? PC_JR : PC_BRANCH;
      flush_ifid = 1'b1;
      flush_idex = 1'b1;
    end else if (load_use) begin
      pc_en      = 1'b0;
      en_ifid    = 1'b0;
      flush_idex = 1'b1;
    end else if (jump_id) begin
      pcsrc      = PC_JUMP;
      flush_ifid = 1'b1;
    end else if (!ihit) begin
      // fetch not back yet
      pc_en      = 1'b0;
      flush_ifid = 1'b1;
    end
  end

  always_comb begin
    a_no_flush_frozen: assert final ((en_ifid || !flush_ifid) && (en_idex || !flush_idex) &&
                                     (en_exmem || !flush_exmem))
      else $error("stage flushed while frozen");
  end

endmodule

/* mips_pipe.f */
+incdir+.
mips_pipe_pkg.sv
control_unit.sv
register_file.sv
alu.sv
forward_unit.sv
hazard_unit.sv
datapath.sv
tb_datapath.sv

/* mips_pipe_pkg.sv */
package mips_pipe_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    ORI   = 6'b001101,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  typedef enum logic [5:0] {
    JR   = 6'b001000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    SLT  = 6'b101010
  } funct_t;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI} aluop_t;

  typedef enum logic {SRC_REG, SRC_IMM} alusrc_t;
  typedef enum logic [1:0] {DST_RD, DST_RT, DST_LINK} regdst_t;
  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_NPC} wbsel_t;
  typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} extsel_t;
  typedef enum logic [1:0] {PC_SEQ, PC_JUMP, PC_BRANCH, PC_JR} pcsrc_t;
  typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwdsel_t;

  // register format
  typedef struct packed {
    opcode_t  opcode;
    regbits_t rs;
    regbits_t rt;
    regbits_t rd;
    logic [4:0] shamt;
    funct_t   funct;
  } r_view_t;

  // immediate format, also carries the jump target in rs, rt and imm
  typedef struct packed {
    opcode_t  opcode;
    regbits_t rs;
    regbits_t rt;
    logic [15:0] imm;
  } i_view_t;

  typedef union packed {
    r_view_t r;
    i_view_t i;
  } instr_t;

endpackage

/* mips_pipe_settings.svh */
`ifndef MIPS_PIPE_SETTINGS_SVH
`define MIPS_PIPE_SETTINGS_SVH

// first fetch address once nRST is released
`define DP_PC_INIT 32'h0000_0000

// return address register for JAL
`define DP_LINK_REG 5'd31

`endif

/* register_file.sv */
module register_file import mips_pipe_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     wen,
  input  regbits_t wsel,
  input  word_t    wdat,
  input  regbits_t rsel1,
  input  regbits_t rsel2,
  output word_t    rdat1,
  output word_t    rdat2
);

  word_t regs [32];
  logic  wr_live;

  // register zero is never written
  assign wr_live = wen && (wsel != '0);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wr_live) begin
      regs[wsel] <= wdat;
    end
  end

  // write-back value seen by ID in the same cycle
  always_comb begin
    rdat1 = regs[rsel1];
    rdat2 = regs[rsel2];
    if (wr_live && (wsel == rsel1)) begin
      rdat1 = wdat;
    end
    if (wr_live && (wsel == rsel2)) begin
      rdat2 = wdat;
    end
  end

  a_zero_reads_zero: assert property (@(posedge CLK) disable iff (!nRST)
    ((rsel1 != '0) || (rdat1 == '0)) && ((rsel2 != '0) || (rdat2 == '0)))
    else $error("register zero read back nonzero");

endmodule

/* tb_datapath.sv */
`include "mips_pipe_settings.svh"

module tb_datapath import mips_pipe_pkg::*; ();

  logic  CLK, nRST;
  logic  ihit, dhit;
  word_t imemload, dmemload;
  logic  imemREN, dmemREN, dmemWEN, halt;
  word_t imemaddr, dmemaddr, dmemstore;

  word_t imem [256];
  word_t dmem [256];
  word_t ref_dmem [256];
  word_t exp_addr [$];
  word_t exp_data [$];

  logic [31:0] lfsr;
  logic [1:0]  i_wait, d_wait;
  logic        i_active, d_active;
  logic        halt_seen;
  int          value_errs, other_errs;
  int          n_ref, n_ref_stores, n_stores, cycles, cycle_limit;

  datapath DUT (
    .CLK(CLK), .nRST(nRST), .ihit(ihit), .imemload(imemload), .dhit(dhit),
    .dmemload(dmemload), .imemREN(imemREN), .imemaddr(imemaddr), .dmemREN(dmemREN),
    .dmemWEN(dmemWEN), .dmemaddr(dmemaddr), .dmemstore(dmemstore), .halt(halt)
  );

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [1:0] wait_cycles();
    logic [1:0] w;
    int k;
    w = '0;
    for (k = 0; k < 2; k++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[0], lfsr[0]};
    end
    return w;
  endfunction

  function automatic word_t rtype_word(funct_t f, regbits_t rs, regbits_t rt, regbits_t rd);
    instr_t w;
    w = '0;
    w.r.opcode = RTYPE;
    w.r.rs = rs;
    w.r.rt = rt;
    w.r.rd = rd;
    w.r.funct = f;
    return w;
  endfunction

  function automatic word_t itype_word(opcode_t op, regbits_t rs, regbits_t rt,
                                       logic [15:0] imm);
    instr_t w;
    w.i.opcode = op;
    w.i.rs = rs;
    w.i.rt = rt;
    w.i.imm = imm;
    return w;
  endfunction

  function automatic word_t jump_word(opcode_t op, logic [25:0] idx);
    return {op, idx};
  endfunction

  function automatic word_t pattern_word(word_t addr);
    return {addr[15:0], addr[31:16]} ^ addr ^ 32'hA5C3_0F1E;
  endfunction

  task automatic load_program();
    int i;
    for (i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] = pattern_word(i * 4);
    end
    // dependent ALU chain
    imem[0]  = itype_word(ORI, 0, 1, 16'h1234);
    imem[1]  = itype_word(LUI, 0, 2, 16'h8000);
    imem[2]  = rtype_word(ADDU, 1, 2, 3);
    imem[3]  = rtype_word(SUBU, 3, 1, 4);
    imem[4]  = rtype_word(AND, 4, 3, 5);
    imem[5]  = rtype_word(OR, 5, 2, 6);
    imem[6]  = rtype_word(SLT, 2, 1, 7);
    imem[7]  = itype_word(ADDIU, 7, 8, 16'hFFFD);
    imem[8]  = itype_word(ORI, 0, 10, 16'h0100);
    imem[9]  = itype_word(SW, 10, 3, 16'd0);
    imem[10] = itype_word(SW, 10, 4, 16'd4);
    imem[11] = itype_word(SW, 10, 5, 16'd8);
    imem[12] = itype_word(SW, 10, 6, 16'd12);
    imem[13] = itype_word(SW, 10, 7, 16'd16);
    imem[14] = itype_word(SW, 10, 8, 16'd20);
    imem[15] = itype_word(ADDIU, 8, 9, 16'd7);
    imem[16] = itype_word(SW, 10, 9, 16'd24);
    // load-use pairs
    imem[17] = itype_word(ORI, 0, 11, 16'h0200);
    imem[18] = itype_word(LW, 11, 12, 16'd0);
    imem[19] = rtype_word(ADDU, 12, 1, 13);
    imem[20] = itype_word(SW, 10, 13, 16'd28);
    imem[21] = itype_word(LW, 11, 14, 16'd4);
    imem[22] = itype_word(SW, 10, 14, 16'd32);
    // branches with stores that mark the wrong paths
    imem[23] = itype_word(BEQ, 7, 0, 16'd2);
    imem[24] = itype_word(ORI, 0, 15, 16'h00A1);
    imem[25] = itype_word(SW, 10, 15, 16'd36);
    imem[26] = itype_word(BNE, 7, 0, 16'd2);
    imem[27] = itype_word(SW, 10, 1, 16'd40);
    imem[28] = itype_word(SW, 10, 2, 16'd40);
    imem[29] = itype_word(ORI, 0, 15, 16'h00B2);
    imem[30] = itype_word(SW, 10, 15, 16'd44);
    imem[31] = itype_word(BNE, 15, 15, 16'd5);
    imem[32] = itype_word(BEQ, 15, 15, 16'd1);
    imem[33] = itype_word(SW, 10, 1, 16'd48);
    imem[34] = jump_word(J, 26'd36);
    imem[35] = itype_word(SW, 10, 2, 16'd48);
    imem[36] = jump_word(JAL, 26'd41);
    imem[37] = itype_word(ORI, 0, 16, 16'h00C3);
    imem[38] = itype_word(SW, 10, 16, 16'd52);
    imem[39] = itype_word(SW, 10, 31, 16'd56);
    imem[40] = jump_word(HALT, 26'd0);
    // subroutine
    imem[41] = itype_word(ORI, 0, 17, 16'h00D4);
    imem[42] = itype_word(SW, 10, 17, 16'd60);
    imem[43] = rtype_word(JR, 31, 0, 0);
    imem[44] = itype_word(SW, 10, 1, 16'd64);
  endtask

  // instruction-level model that returns the number of instructions run
  function automatic int run_reference();
    word_t  regs [32];
    word_t  pc, a, b, imm_s, imm_z, addr;
    instr_t ins;
    int     n;
    regs = '{default: '0};
    ref_dmem = dmem;
    pc = `DP_PC_INIT;
    n = 0;
    while (n < 1000) begin
      ins = imem[pc[9:2]];
      n++;
      a = regs[ins.r.rs];
      b = regs[ins.r.rt];
      imm_s = {{16{ins.i.imm[15]}}, ins.i.imm};
      imm_z = {16'h0000, ins.i.imm};
      addr = a + imm_s;
      pc = pc + 32'd4;
      case (ins.r.opcode)
        RTYPE: begin
          case (ins.r.funct)
            ADDU: regs[ins.r.rd] = a + b;
            SUBU: regs[ins.r.rd] = a - b;
            AND:  regs[ins.r.rd] = a & b;
            OR:   regs[ins.r.rd] = a | b;
            SLT:  regs[ins.r.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            JR:   pc = a;
            default: ;
          endcase
        end
        ADDIU: regs[ins.i.rt] = a + imm_s;
        ORI:   regs[ins.i.rt] = a | imm_z;
        LUI:   regs[ins.i.rt] = {ins.i.imm, 16'h0000};
        LW:    regs[ins.i.rt] = ref_dmem[addr[9:2]];
        SW: begin
          ref_dmem[addr[9:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        BEQ: if (a == b) pc = pc + (imm_s << 2);
        BNE: if (a != b) pc = pc + (imm_s << 2);
        J:   pc = {pc[31:28], ins[25:0], 2'b00};
        JAL: begin
          regs[`DP_LINK_REG] = pc;
          pc = {pc[31:28], ins[25:0], 2'b00};
        end
        HALT: return n;
        default: ;
      endcase
      regs[0] = '0;
    end
    return n;
  endfunction

  task automatic check_level(string what, logic got, logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL t=%0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_word(string what, word_t got, word_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL t=%0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_store(word_t addr, word_t data);
    word_t ea, ed;
    if (exp_addr.size() == 0) begin
      other_errs++;
      $display("unexpected extra store of %h to %h at time %0t", data, addr, $time);
    end else begin
      ea = exp_addr.pop_front();
      ed = exp_data.pop_front();
      if ((addr !== ea) || (data !== ed)) begin
        value_errs++;
        $display("FAIL t=%0t: store %h to %h, expected %h to %h", $time, data, addr, ed, ea);
      end
    end
  endtask

  // memory model answers each request after 0 to 3 wait cycles
  always @(posedge CLK) begin
    if (!nRST) begin
      #1;
      ihit = 1'b0;
      dhit = 1'b0;
      i_active = 1'b0;
      d_active = 1'b0;
    end else begin
      #1;
      ihit = 1'b0;
      dhit = 1'b0;
      if (imemREN) begin
        if (!i_active) begin
          i_wait = wait_cycles();
          i_active = 1'b1;
        end
        if (i_wait == 2'd0) begin
          ihit = 1'b1;
          imemload = imem[imemaddr[9:2]];
          i_active = 1'b0;
        end else begin
          i_wait = i_wait - 2'd1;
        end
      end else begin
        i_active = 1'b0;
      end
      if (dmemREN || dmemWEN) begin
        if (!d_active) begin
          d_wait = wait_cycles();
          d_active = 1'b1;
        end
        if (d_wait == 2'd0) begin
          dhit = 1'b1;
          dmemload = dmem[dmemaddr[9:2]];
          if (dmemWEN) begin
            dmem[dmemaddr[9:2]] = dmemstore;
          end
          d_active = 1'b0;
        end else begin
          d_wait = d_wait - 2'd1;
        end
      end else begin
        d_active = 1'b0;
      end
    end
  end

  // completed stores and the halt rules sampled mid-cycle
  always @(negedge CLK) begin
    if (nRST) begin
      if (dhit && dmemWEN) begin
        n_stores++;
        check_store(dmemaddr, dmemstore);
      end
      if (cycles > 0 && halt && (imemREN || dmemREN || dmemWEN)) begin
        other_errs++;
        $display("memory request issued after halt at time %0t", $time);
      end
      if (halt_seen) begin
        check_level("halt held", halt, 1'b1);
      end
      if (halt) begin
        halt_seen = 1'b1;
      end
    end
  end

  always @(posedge CLK) begin
    if (nRST && !halt) begin
      cycles++;
      if (cycles > cycle_limit) begin
        $display("timeout: halt not seen within %0d cycles", cycle_limit);
        $display("errors: %0d value, %0d other", value_errs, other_errs + 1);
        $display("Simulation finished: FAIL");
        $finish;
      end
    end
  end

  initial begin
    int i;
    nRST = 1'b0;
    ihit = 1'b0;
    dhit = 1'b0;
    imemload = '0;
    dmemload = '0;
    lfsr = 32'h273b;
    halt_seen = 1'b0;
    value_errs = 0;
    other_errs = 0;
    n_stores = 0;
    cycles = 0;
    load_program();
    n_ref = run_reference();
    n_ref_stores = exp_addr.size();
    cycle_limit = 40 * n_ref + 200;

    repeat (2) @(posedge CLK);
    #1;
    check_word("imemaddr in reset", imemaddr, `DP_PC_INIT);
    check_level("imemREN in reset", imemREN, 1'b1);
    check_level("dmemREN in reset", dmemREN, 1'b0);
    check_level("dmemWEN in reset", dmemWEN, 1'b0);
    check_level("halt in reset", halt, 1'b0);
    repeat (3) @(posedge CLK);
    #1 nRST = 1'b1;

    while (!halt) @(posedge CLK);
    // idle a while so late requests or a falling halt show up
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    #1;

    if (n_stores != n_ref_stores) begin
      other_errs++;
      $display("store count %0d does not match expected %0d", n_stores, n_ref_stores);
    end
    for (i = 0; i < 256; i++) begin
      check_word($sformatf("data word %h", i * 4), dmem[i], ref_dmem[i]);
    end

    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
